// ==== dv/azseq_cases.txt ====
// precharge seq_n entry0 entry1 entry2 entry3 results, then one adc data word per result
// entry is {pc[1:0], azmux[3:0]}, all values hex, ffffffff ends the list
3 1 13 04 25 36 5   a10001 3ffffe 123456 800000 0007f1
0 0 2a 00 00 00 3   000001 fedcba 55aa55
5 2 11 02 2c 00 7   400000 400001 3ffff0 00beef 7abcde 000000 ffffff
2 3 31 09 1e 27 9   100000 200000 300000 400000 500000 600000 700000 0c0ffe 123abc
ffffffff

// ==== filelist.f ====
common/azseq_pkg.sv
design/azseq_regs.sv
sequencer/azseq_sequencer.sv
adc/adc_front.sv
design/azseq_top.sv
dv/azseq_asserts.sv
dv/azseq_tb.sv

// ==== Bender.yml ====
package:
  name: azseq

sources:
  - common/azseq_pkg.sv
  - design/azseq_regs.sv
  - sequencer/azseq_sequencer.sv
  - adc/adc_front.sv
  - design/azseq_top.sv
  - target: test
    files:
      - dv/azseq_asserts.sv
      - dv/azseq_tb.sv

// ==== dv/azseq_tb.sv ====
// testbench for the auto-zero sequencer with clock, reset, host writes, adc model and checks

`timescale 1ns/1ps

module azseq_tb;

  import azseq_pkg::*;

  // dut connections
  logic                  clk;
  logic                  reset_n;
  logic                  cfg_we;
  azseq_reg_e            cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic                  adc_done = 1'b0;
  logic [ADC_DATA_W-1:0] adc_data = '0;
  logic [AZ_MUX_W-1:0]   azmux;
  logic [AZ_PC_W-1:0]    sw_pc;
  logic                  adc_reset_n;
  az_result_t            result;
  logic                  result_valid;

  // case file image, one case per line
  logic [31:0] case_mem [0:255];

  // host side copy of the register bank
  logic [AZ_CNT_W-1:0] cur_prech = AZ_PRECHARGE_DEF;
  logic [AZ_IDX_W-1:0] cur_seq_n = 2'd1;
  az_entry_t           cur_seq [AZ_MAX_ENTRIES];

  // expected next record, and data queues for the adc model and the checker
  logic [AZ_IDX_W-1:0]   exp_idx = '0;
  az_entry_t             exp_entry = '0;
  logic [ADC_DATA_W-1:0] exp_word;
  logic [ADC_DATA_W-1:0] exp_words [$];
  logic [ADC_DATA_W-1:0] adc_words [$];

  int    err_cnt = 0;
  int    res_total = 0;
  int    got = 0;
  int    want = 0;
  int    cycle_cnt = 0;
  int    cycle_limit = 100000;
  int    gap_cnt = 0;
  logic  gap_armed = 1'b0;
  string case_name = "reset";

  // adc model state
  int    delay_left = 0;
  logic  conv_seen = 1'b0;

  azseq_top u_azseq_top (
    .clk            (clk),
    .reset_n        (reset_n),
    .cfg_we_i       (cfg_we),
    .cfg_addr_i     (cfg_addr),
    .cfg_wdata_i    (cfg_wdata),
    .adc_done_i     (adc_done),
    .adc_data_i     (adc_data),
    .azmux_o        (azmux),
    .sw_pc_o        (sw_pc),
    .adc_reset_n_o  (adc_reset_n),
    .result_o       (result),
    .result_valid_o (result_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic show_mismatch(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    err_cnt++;
    $display("CHECK FAILED %s %s: expected %0h, actual %0h", case_name, what, exp_v, act_v);
  endtask

  // one host write, called just after a falling edge
  task automatic reg_write(input azseq_reg_e addr, input logic [31:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    // fields truncated the same way the bank does
    case (addr)
      REG_PRECHARGE: cur_prech = data[AZ_CNT_W-1:0];
      REG_SEQ_N:     cur_seq_n = data[AZ_IDX_W-1:0];
      REG_SEQ0, REG_SEQ1, REG_SEQ2, REG_SEQ3:
        cur_seq[addr - REG_SEQ0] = az_entry_t'(data[AZ_ENTRY_W-1:0]);
      default: ;
    endcase
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  //////////////////////////////
  // adc model, random conversion time of 2 to 20 cycles
  always @(negedge clk)
  begin
    adc_done = 1'b0;
    if (!adc_reset_n)
      conv_seen = 1'b0;
    else if (!conv_seen)
    begin
      conv_seen  = 1'b1;
      delay_left = 2 + ($urandom % 19);
    end
    else if (delay_left > 1)
      delay_left = delay_left - 1;
    else if (delay_left == 1)
    begin
      delay_left = 0;
      adc_done   = 1'b1;
      if (adc_words.size() > 0)
        adc_data = adc_words.pop_front();
      else
      begin
        err_cnt++;
        $display("adc model has no conversion word left in %s", case_name);
      end
    end
  end

  // run limit
  always @(negedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("timeout after %0d cycles in %s, %0d of %0d results seen",
               cycle_limit, case_name, got, want);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // output monitor, samples between edges
  always @(negedge clk)
  begin
    if (reset_n)
    begin
      // switches hold the sampled entry for the whole conversion
      if (adc_reset_n && {sw_pc, azmux} !== exp_entry)
        show_mismatch("switches during conversion", exp_entry, {sw_pc, azmux});
      // three dwells at least from a result to the next reset release
      if (gap_armed && adc_reset_n)
      begin
        gap_armed = 1'b0;
        if (gap_cnt < 3 * (cur_prech + 1))
          show_mismatch("dwell gap minimum", 3 * (cur_prech + 1), gap_cnt);
      end
      else if (gap_armed)
        gap_cnt++;
      if (result_valid && got >= want)
      begin
        err_cnt++;
        $display("unexpected result record with index %0d in %s", result.index, case_name);
      end
      else if (result_valid)
      begin
        exp_word = exp_words.pop_front();
        if (result.index !== exp_idx)
          show_mismatch("result index", exp_idx, result.index);
        if (result.entry !== exp_entry)
          show_mismatch("result entry", exp_entry, result.entry);
        if (result.data !== exp_word)
          show_mismatch("result data", exp_word, result.data);
        got++;
        res_total++;
        gap_armed = 1'b1;
        gap_cnt   = 1;
        // next sample sees the registers as they stand now
        exp_idx   = (exp_idx == cur_seq_n) ? '0 : exp_idx + 1'b1;
        exp_entry = cur_seq[exp_idx];
      end
    end
  end

  //////////////////////////////
  // main sequence
  initial
  begin
    int        p;
    int        n;
    int        k;
    int        case_no;
    az_entry_t new_e;

    void'($urandom(32'h4e6e));
    reset_n   = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = REG_PRECHARGE;
    cfg_wdata = '0;
    for (k = 0; k < AZ_MAX_ENTRIES; k++)
      cur_seq[k] = '0;

    // limit grows with every case in the file
    $readmemh("dv/azseq_cases.txt", case_mem);
    p = 0;
    cycle_limit = 200;
    while (p < 240 && case_mem[p] !== 32'hffffffff)
    begin
      n = case_mem[p+6];
      cycle_limit += n * (3 * (case_mem[p] + 1) + 25) + 3 * (case_mem[p] + 1) + 60;
      p += 7 + n;
    end

    repeat (5) @(negedge clk);
    reset_n = 1'b1;

    // run clear, adc in reset and switches parked
    repeat (20)
    begin
      @(negedge clk);
      if ({adc_reset_n, result_valid, sw_pc, azmux} !== {2'b00, PC_BOOT, 4'h0})
        show_mismatch("idle outputs", {2'b00, PC_BOOT, 4'h0},
                      {adc_reset_n, result_valid, sw_pc, azmux});
    end

    p = 0;
    case_no = 0;
    while (p < 240 && case_mem[p] !== 32'hffffffff)
    begin
      case_name = $sformatf("case%0d", case_no);
      n = case_mem[p+6];
      reg_write(REG_PRECHARGE, case_mem[p]);
      reg_write(REG_SEQ_N, case_mem[p+1]);
      for (k = 0; k < AZ_MAX_ENTRIES; k++)
        reg_write(azseq_reg_e'(REG_SEQ0 + k), case_mem[p+2+k]);
      for (k = 0; k < n; k++)
      begin
        exp_words.push_back(case_mem[p+7+k][ADC_DATA_W-1:0]);
        adc_words.push_back(case_mem[p+7+k][ADC_DATA_W-1:0]);
      end
      // every run starts over at index zero
      exp_idx   = '0;
      exp_entry = cur_seq[0];
      got       = 0;
      want      = n;
      gap_armed = 1'b0;
      reg_write(REG_CTRL, 32'd1);

      // rewrite the entry of the second sample as it parks
      // that sample keeps the old setting and later visits of its index take the new one
      wait (got == 1);
      @(negedge clk);
      new_e = cur_seq[exp_idx] ^ 6'h15;
      reg_write(azseq_reg_e'(REG_SEQ0 + exp_idx), 32'(new_e));

      // stop while the last sample converts
      while (!(got == n - 1 && adc_reset_n))
        @(negedge clk);
      reg_write(REG_CTRL, 32'd0);
      wait (got == n);

      // stopped, nothing more may come out
      repeat (3 * (cur_prech + 1) + 30)
      begin
        @(negedge clk);
        if (adc_reset_n !== 1'b0)
          show_mismatch("adc reset while stopped", 0, adc_reset_n);
      end
      p += 7 + n;
      case_no++;
    end

    if (case_no == 0)
    begin
      err_cnt++;
      $display("no cases could be read from dv/azseq_cases.txt");
    end
    $display("results %0d, cases %0d, errors %0d", res_total, case_no, err_cnt);
    if (err_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== dv/azseq_asserts.sv ====
// concurrent checks on switch ordering, start strobe, adc reset window and result strobe

`timescale 1ns/1ps

module azseq_asserts (
  input  logic                           clk,
  input  logic                           reset_n,
  input  azseq_pkg::azseq_state_e        state_i,
  input  logic [azseq_pkg::AZ_MUX_W-1:0] azmux_i,
  input  logic [azseq_pkg::AZ_PC_W-1:0]  sw_pc_i,
  input  logic                           conv_start_i,
  input  logic                           adc_done_i,
  input  logic                           adc_reset_n_i,
  input  logic                           result_valid_i
);

  import azseq_pkg::*;

  // azmux moves only out of MUX_SET and with precharge parked on boot
  sw_order_a: assert property (@(posedge clk) disable iff (!reset_n)
    $changed(azmux_i) |-> (sw_pc_i == PC_BOOT) && ($past(state_i) == MUX_SET))
  else $error("azmux changed without the precharge switch parked on boot");

  // start is a single cycle strobe
  start_pulse_a: assert property (@(posedge clk) disable iff (!reset_n)
    conv_start_i |=> !conv_start_i)
  else $error("conv_start held for more than one cycle");

  // adc leaves reset only the cycle after a start
  reset_rise_a: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(adc_reset_n_i) |-> $past(conv_start_i))
  else $error("adc released from reset without a start");

  // done while converting puts the adc back into reset
  reset_fall_a: assert property (@(posedge clk) disable iff (!reset_n)
    adc_reset_n_i && adc_done_i |=> !adc_reset_n_i)
  else $error("adc still out of reset after its done");

  // a result needs a conversion that was running
  result_a: assert property (@(posedge clk) disable iff (!reset_n)
    result_valid_i |-> $past(adc_reset_n_i) && $past(adc_done_i))
  else $error("result strobe without a running conversion");

endmodule

// sequencer side, adc inputs held idle
bind azseq_sequencer azseq_asserts u_seq_asserts (
  .clk            (clk),
  .reset_n        (reset_n),
  .state_i        (state_q),
  .azmux_i        (azmux_o),
  .sw_pc_i        (sw_pc_o),
  .conv_start_i   (conv_start_o),
  .adc_done_i     (1'b0),
  .adc_reset_n_i  (1'b0),
  .result_valid_i (1'b0)
);

// adc front side, switch inputs held parked
bind adc_front azseq_asserts u_adc_asserts (
  .clk            (clk),
  .reset_n        (reset_n),
  .state_i        (azseq_pkg::IDLE),
  .azmux_i        (4'h0),
  .sw_pc_i        (azseq_pkg::PC_BOOT),
  .conv_start_i   (conv_start_i),
  .adc_done_i     (adc_done_i),
  .adc_reset_n_i  (adc_reset_n_o),
  .result_valid_i (result_valid_o)
);

// ==== design/azseq_top.sv ====
// top level wiring of register bank, sequencer and adc front

`timescale 1ns/1ps

module azseq_top (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 cfg_we_i,
  input  azseq_pkg::azseq_reg_e                cfg_addr_i,
  input  logic [azseq_pkg::CFG_DATA_W-1:0]     cfg_wdata_i,
  input  logic                                 adc_done_i,
  input  logic [azseq_pkg::ADC_DATA_W-1:0]     adc_data_i,
  output logic [azseq_pkg::AZ_MUX_W-1:0]       azmux_o,
  output logic [azseq_pkg::AZ_PC_W-1:0]        sw_pc_o,
  output logic                                 adc_reset_n_o,
  output azseq_pkg::az_result_t                result_o,
  output logic                                 result_valid_o
);

  import azseq_pkg::*;

  // register bank to sequencer
  azseq_cfg_t          cfg;

  // sequencer to adc front and back
  logic                conv_start;
  logic                conv_done;
  az_entry_t           conv_entry;
  logic [AZ_IDX_W-1:0] conv_index;

  azseq_regs u_azseq_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (cfg)
  );

  azseq_sequencer u_azseq_sequencer (
    .clk          (clk),
    .reset_n      (reset_n),
    .cfg_i        (cfg),
    .conv_done_i  (conv_done),
    .azmux_o      (azmux_o),
    .sw_pc_o      (sw_pc_o),
    .conv_start_o (conv_start),
    .conv_entry_o (conv_entry),
    .conv_index_o (conv_index)
  );

  adc_front u_adc_front (
    .clk            (clk),
    .reset_n        (reset_n),
    .conv_start_i   (conv_start),
    .conv_entry_i   (conv_entry),
    .conv_index_i   (conv_index),
    .adc_done_i     (adc_done_i),
    .adc_data_i     (adc_data_i),
    .adc_reset_n_o  (adc_reset_n_o),
    .conv_done_o    (conv_done),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

// ==== adc/adc_front.sv ====
// adc reset control and capture of conversion data into the result record

`timescale 1ns/1ps

module adc_front (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 conv_start_i,
  input  azseq_pkg::az_entry_t                 conv_entry_i,
  input  logic [azseq_pkg::AZ_IDX_W-1:0]       conv_index_i,
  input  logic                                 adc_done_i,
  input  logic [azseq_pkg::ADC_DATA_W-1:0]     adc_data_i,
  output logic                                 adc_reset_n_o,
  output logic                                 conv_done_o,
  output azseq_pkg::az_result_t                result_o,
  output logic                                 result_valid_o
);

  import azseq_pkg::*;

  // high while a conversion is pending, doubles as the adc reset release
  logic                busy_q;
  logic                done_q;

  // tags latched at start
  az_entry_t           entry_q;
  logic [AZ_IDX_W-1:0] index_q;

  assign adc_reset_n_o  = busy_q;

  // same strobe goes to the host and back to the sequencer
  assign conv_done_o    = done_q;
  assign result_valid_o = done_q;

  //////////////////////////////
  // conversion control
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      if (conv_start_i)
        busy_q <= 1'b1;
      else if (busy_q && adc_done_i)
      begin
        // back into reset on the done edge
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      // a stray done with nothing pending falls through
    end
  end

  //////////////////////////////
  // tags and result record
  // previous record holds while the next entry switches
  always_ff @(posedge clk)
  begin
    if (conv_start_i)
    begin
      entry_q <= conv_entry_i;
      index_q <= conv_index_i;
    end
    if (busy_q && adc_done_i && !conv_start_i)
    begin
      result_o.index <= index_q;
      result_o.entry <= entry_q;
      result_o.data  <= adc_data_i;
    end
  end

endmodule

// ==== sequencer/azseq_sequencer.sv ====
// auto-zero phase state machine, steps precharge and azmux switches and counts dwells

`timescale 1ns/1ps

module azseq_sequencer (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  azseq_pkg::azseq_cfg_t                cfg_i,
  input  logic                                 conv_done_i,
  output logic [azseq_pkg::AZ_MUX_W-1:0]       azmux_o,
  output logic [azseq_pkg::AZ_PC_W-1:0]        sw_pc_o,
  output logic                                 conv_start_o,
  output azseq_pkg::az_entry_t                 conv_entry_o,
  output logic [azseq_pkg::AZ_IDX_W-1:0]       conv_index_o
);

  import azseq_pkg::*;

  azseq_state_e        state_q;

  // single down-counter shared by all three dwells
  logic [AZ_CNT_W-1:0] cnt_q;
  logic                cnt_zero;

  // sample index, and the config captured for the sample in progress
  logic [AZ_IDX_W-1:0] idx_q;
  logic [AZ_IDX_W-1:0] idx_sel;
  logic [AZ_CNT_W-1:0] precharge_q;
  logic [AZ_IDX_W-1:0] seq_n_q;
  az_entry_t           entry_q;

  assign cnt_zero = (cnt_q == '0);

  // host may have shortened the sequence, restart at entry zero then
  assign idx_sel = (idx_q > cfg_i.seq_n) ? '0 : idx_q;

  // entry and index stay stable from PC_PARK to the end of MEASURE
  assign conv_entry_o = entry_q;
  assign conv_index_o = idx_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_q      <= IDLE;
      cnt_q        <= '0;
      idx_q        <= '0;
      azmux_o      <= '0;
      sw_pc_o      <= PC_BOOT;
      conv_start_o <= 1'b0;
    end
    else
    begin
      // start is a single cycle strobe
      conv_start_o <= 1'b0;

      case (state_q)
        IDLE:
        begin
          // keep the signal protected while stopped
          sw_pc_o <= PC_BOOT;
          if (cfg_i.run)
            state_q <= PC_PARK;
        end

        //////////////////////////////
        // park precharge on boot, capture the sample config
        PC_PARK:
        begin
          sw_pc_o     <= PC_BOOT;
          idx_q       <= idx_sel;
          entry_q     <= cfg_i.seq[idx_sel];
          precharge_q <= cfg_i.precharge;
          seq_n_q     <= cfg_i.seq_n;
          cnt_q       <= cfg_i.precharge;
          state_q     <= PC_WAIT;
        end

        PC_WAIT:
          if (cnt_zero)
            state_q <= MUX_SET;
          else
            cnt_q <= cnt_q - 1'b1;

        //////////////////////////////
        // azmux to the input of interest, may be a lo
        MUX_SET:
        begin
          azmux_o <= entry_q.azmux;
          cnt_q   <= precharge_q;
          state_q <= MUX_WAIT;
        end

        MUX_WAIT:
          if (cnt_zero)
            state_q <= PC_SET;
          else
            cnt_q <= cnt_q - 1'b1;

        //////////////////////////////
        // precharge from boot to the entry setting
        // a lo sample with pc equal to boot changes nothing, timing kept the same
        PC_SET:
        begin
          sw_pc_o <= entry_q.pc;
          cnt_q   <= precharge_q;
          state_q <= PC_SET_WAIT;
        end

        PC_SET_WAIT:
          if (cnt_zero)
          begin
            conv_start_o <= 1'b1;
            state_q      <= MEASURE;
          end
          else
            cnt_q <= cnt_q - 1'b1;

        // adc front owns the conversion, wait for its done strobe
        MEASURE:
          if (conv_done_i)
          begin
            // a cleared run stops here, restart is always at index zero
            if (!cfg_i.run)
            begin
              idx_q   <= '0;
              state_q <= IDLE;
            end
            else
            begin
              idx_q   <= (idx_q == seq_n_q) ? '0 : idx_q + 1'b1;
              state_q <= PC_PARK;
            end
          end

        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// ==== design/azseq_regs.sv ====
// host register bank, decodes single cycle writes into the sequencer configuration

`timescale 1ns/1ps

module azseq_regs (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 cfg_we_i,
  input  azseq_pkg::azseq_reg_e                cfg_addr_i,
  input  logic [azseq_pkg::CFG_DATA_W-1:0]     cfg_wdata_i,
  output azseq_pkg::azseq_cfg_t                cfg_o
);

  import azseq_pkg::*;

  // control fields, cleared by reset
  logic [AZ_CNT_W-1:0] precharge_q;
  logic [AZ_IDX_W-1:0] seq_n_q;
  logic                run_q;

  // sequence entries, host must write them before setting run
  az_entry_t [AZ_MAX_ENTRIES-1:0] seq_q;

  // write data truncated to each field
  az_entry_t           wr_entry;

  assign wr_entry = az_entry_t'(cfg_wdata_i[AZ_ENTRY_W-1:0]);

  //////////////////////////////
  // control registers
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      // default is a two entry sequence, hi then lo
      precharge_q <= AZ_PRECHARGE_DEF;
      seq_n_q     <= 2'd1;
      run_q       <= 1'b0;
    end
    else if (cfg_we_i)
    begin
      case (cfg_addr_i)
        REG_PRECHARGE: precharge_q <= cfg_wdata_i[AZ_CNT_W-1:0];
        REG_SEQ_N:     seq_n_q     <= cfg_wdata_i[AZ_IDX_W-1:0];
        REG_CTRL:      run_q       <= cfg_wdata_i[0];
        default:       ;
      endcase
    end
  end

  //////////////////////////////
  // entry registers
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (cfg_we_i)
    begin
      case (cfg_addr_i)
        REG_SEQ0: seq_q[0] <= wr_entry;
        REG_SEQ1: seq_q[1] <= wr_entry;
        REG_SEQ2: seq_q[2] <= wr_entry;
        REG_SEQ3: seq_q[3] <= wr_entry;
        default:  ;
      endcase
    end
  end

  // config goes out as a level, sequencer latches what it needs
  always_comb
  begin
    cfg_o.precharge = precharge_q;
    cfg_o.seq_n     = seq_n_q;
    cfg_o.seq       = seq_q;
    cfg_o.run       = run_q;
  end

endmodule

// ==== common/azseq_pkg.sv ====
// shared widths, register addresses, sequencer states, entry/config/result structs

package azseq_pkg;

  //////////////////////////////
  // widths and sizes fixed by the board
  //////////////////////////////

  // one entry packs the azmux select and the precharge switch
  localparam int AZ_MUX_W       = 4;
  localparam int AZ_PC_W        = 2;
  localparam int AZ_ENTRY_W     = AZ_MUX_W + AZ_PC_W;

  // up to four entries per sequence, index is two bits
  localparam int AZ_MAX_ENTRIES = 4;
  localparam int AZ_IDX_W       = 2;

  // dwell counter and adc conversion word
  localparam int AZ_CNT_W       = 24;
  localparam int ADC_DATA_W     = 24;

  // host bus
  localparam int CFG_ADDR_W     = 3;
  localparam int CFG_DATA_W     = 32;

  // precharge switch parked on boot, protects the input from azmux charge injection
  localparam logic [AZ_PC_W-1:0] PC_BOOT = 2'b00;

  // dwell out of reset, a precharge count of 9 gives 10 cycles per dwell
  localparam logic [AZ_CNT_W-1:0] AZ_PRECHARGE_DEF = 24'd9;

  //////////////////////////////
  // host register map
  //////////////////////////////
  typedef enum logic [CFG_ADDR_W-1:0] {
    REG_PRECHARGE = 3'd0,
    REG_SEQ_N     = 3'd1,
    REG_SEQ0      = 3'd2,
    REG_SEQ1      = 3'd3,
    REG_SEQ2      = 3'd4,
    REG_SEQ3      = 3'd5,
    REG_CTRL      = 3'd6
  } azseq_reg_e;

  // sequencer phases, one set/wait pair per switch step
  typedef enum logic [2:0] {
    IDLE,
    PC_PARK,
    PC_WAIT,
    MUX_SET,
    MUX_WAIT,
    PC_SET,
    PC_SET_WAIT,
    MEASURE
  } azseq_state_e;

  //////////////////////////////
  // structs
  //////////////////////////////

  // pc sits in the upper two bits, azmux in the low four
  typedef struct packed {
    logic [AZ_PC_W-1:0]  pc;
    logic [AZ_MUX_W-1:0] azmux;
  } az_entry_t;

  typedef struct packed {
    logic [AZ_CNT_W-1:0]                  precharge;
    logic [AZ_IDX_W-1:0]                  seq_n;
    az_entry_t [AZ_MAX_ENTRIES-1:0]       seq;
    logic                                 run;
  } azseq_cfg_t;

  // one record per measurement
  typedef struct packed {
    logic [AZ_IDX_W-1:0]   index;
    az_entry_t             entry;
    logic [ADC_DATA_W-1:0] data;
  } az_result_t;

endpackage
